// File: source/playfield_pkg.sv
// **********************************************************************
// playfield package
// widths, depth codes and the word group struct shared by the
// bitmap playfield line generator
// **********************************************************************
`default_nettype none

package playfield_pkg;

    typedef logic [15:0] addr_t;                    // vram word address
    typedef logic [15:0] word_t;                    // vram data word
    typedef logic [7:0]  color_t;                   // colour index
    typedef logic [10:0] hres_t;                    // horizontal count
    typedef logic [63:0] pixels_t;                  // eight indices, leftmost in top byte

    typedef logic [1:0]  bpp_t;                     // pixel depth code

    localparam bpp_t BPP_1_ATTR = 2'd0;             // 1 word per group, fore/back in upper byte
    localparam bpp_t BPP_4      = 2'd1;             // 2 words per group
    localparam bpp_t BPP_8      = 2'd2;             // 4 words per group
    localparam bpp_t BPP_XX     = 2'd3;             // handled as 8 bpp

    // raw display words for one group of eight pixels
    typedef struct packed {
        word_t word0;                               // first word fetched
        word_t word1;
        word_t word2;
        word_t word3;                               // last word, 8 bpp only
    } pf_words_t;

    localparam int SCAN_LEAD = 1;                   // scan strobe this many counts before left edge

endpackage

`default_nettype wire

// File: source/playfield_fetch.sv
// **********************************************************************
// playfield line fetch
// issues vram reads for each group of eight pixels and collects
// the one, two or four words that the pixel depth needs
// **********************************************************************
`default_nettype none
`timescale 1ns/1ns

module playfield_fetch (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       stall_i,            // freeze fetch this cycle
    input  wire logic                       mem_fetch_start_i,  // line fetch start strobe
    input  wire logic                       end_of_line_i,      // end of scanline strobe
    input  wire playfield_pkg::bpp_t        bpp_i,              // pixel depth
    input  wire playfield_pkg::addr_t       line_start_i,       // start address of this line
    input  wire logic                       buf_full_i,         // expander holds a group
    output      logic                       vram_sel_o,         // vram read select
    output      playfield_pkg::addr_t       vram_addr_o,        // vram read address
    input  wire playfield_pkg::word_t       vram_data_i,        // data one cycle after address
    output      logic                       words_ready_o,      // previous group complete
    output      playfield_pkg::pf_words_t   words_o             // words of previous group
);

typedef enum logic [2:0] {
    FETCH_IDLE,                                     // restart point after line strobes
    FETCH_ADDR,                                     // first address out when buffer has room
    FETCH_WAIT,                                     // data latency, second address for 4/8 bpp
    FETCH_READ_0,
    FETCH_READ_1,
    FETCH_READ_2,
    FETCH_READ_3
} fetch_state_t;

fetch_state_t               state, state_next;
playfield_pkg::addr_t       pf_addr, pf_addr_next;  // running display address
playfield_pkg::addr_t       fetch_addr_next;        // next vram address
logic                       sel_next;               // next vram select
logic                       initial_buf, initial_buf_next; // first group of line pending
playfield_pkg::pf_words_t   words_q, words_next;
logic                       one_word;               // 1 bpp group
logic                       two_words;              // 4 bpp group

assign one_word      = (bpp_i == playfield_pkg::BPP_1_ATTR);
assign two_words     = (bpp_i == playfield_pkg::BPP_4);
assign words_ready_o = (state == FETCH_WAIT) && !initial_buf && !stall_i; // words_q is the old group here
assign words_o       = words_q;

always_comb begin
    state_next       = state;
    pf_addr_next     = pf_addr;
    fetch_addr_next  = vram_addr_o;                 // address holds when idle
    sel_next         = 1'b0;
    initial_buf_next = initial_buf;
    words_next       = words_q;

    case (state)
        FETCH_IDLE: state_next = FETCH_ADDR;
        FETCH_ADDR: begin
            if (!buf_full_i) begin                  // wait for room in pixel buffer
                sel_next        = 1'b1;             // word0 address
                fetch_addr_next = pf_addr;
                pf_addr_next    = pf_addr + 1'b1;
                state_next      = FETCH_WAIT;
            end
        end
        FETCH_WAIT: begin
            if (!one_word) begin
                sel_next        = 1'b1;             // word1 address
                fetch_addr_next = pf_addr;
                pf_addr_next    = pf_addr + 1'b1;
            end
            initial_buf_next = 1'b0;
            state_next       = FETCH_READ_0;
        end
        FETCH_READ_0: begin
            words_next.word0 = vram_data_i;
            if (one_word) begin
                state_next = FETCH_ADDR;
            end else begin
                if (!two_words) begin
                    sel_next        = 1'b1;         // word2 address
                    fetch_addr_next = pf_addr;
                    pf_addr_next    = pf_addr + 1'b1;
                end
                state_next = FETCH_READ_1;
            end
        end
        FETCH_READ_1: begin
            words_next.word1 = vram_data_i;
            if (two_words) begin
                state_next = FETCH_ADDR;
            end else begin
                sel_next        = 1'b1;             // word3 address
                fetch_addr_next = pf_addr;
                pf_addr_next    = pf_addr + 1'b1;
                state_next      = FETCH_READ_2;
            end
        end
        FETCH_READ_2: begin
            words_next.word2 = vram_data_i;
            state_next       = FETCH_READ_3;
        end
        FETCH_READ_3: begin
            words_next.word3 = vram_data_i;
            state_next       = FETCH_ADDR;
        end
        default: state_next = FETCH_IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state       <= FETCH_IDLE;
        pf_addr     <= '0;
        initial_buf <= 1'b1;
        vram_sel_o  <= 1'b0;
        vram_addr_o <= '0;
    end else begin
        if (!stall_i) begin
            state       <= state_next;
            pf_addr     <= pf_addr_next;
            initial_buf <= initial_buf_next;
            vram_sel_o  <= sel_next;
            vram_addr_o <= fetch_addr_next;
        end
        if (mem_fetch_start_i || end_of_line_i) begin   // restart even when stalled
            state       <= FETCH_IDLE;
            pf_addr     <= line_start_i;
            initial_buf <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (!stall_i) begin
        words_q <= words_next;                      // word registers freeze with the FSM
    end
end

endmodule

`default_nettype wire

// File: source/playfield_expand.sv
// **********************************************************************
// playfield pixel buffer
// expands one group of fetched words into eight colour indices
// and tracks whether the buffer waits for the scanout
// **********************************************************************
`default_nettype none
`timescale 1ns/1ns

module playfield_expand (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire playfield_pkg::bpp_t        bpp_i,              // pixel depth
    input  wire logic                       words_ready_i,      // load strobe from fetch
    input  wire playfield_pkg::pf_words_t   words_i,            // raw group words
    input  wire logic                       take_i,             // scanout copied buffer
    input  wire logic                       line_start_strobe_i,// new line, drop buffer
    output      logic                       buf_full_o,         // buffer holds a group
    output      playfield_pkg::pixels_t     pixels_o            // buffered pixels
);

playfield_pkg::pixels_t expanded;                   // combinational expansion
logic [31:0]            nibbles;                    // word0 and word1 for 4 bpp

always_comb begin
    nibbles  = {words_i.word0, words_i.word1};
    expanded = words_i;                             // 8 bpp, bytes already in order
    case (bpp_i)
        playfield_pkg::BPP_1_ATTR: begin
            for (int i = 0; i < 8; i++) begin       // msb is leftmost, set bit picks foreground
                expanded[63-8*i -: 8] = {4'h0, words_i.word0[7-i] ?
                                         words_i.word0[11:8] : words_i.word0[15:12]};
            end
        end
        playfield_pkg::BPP_4: begin
            for (int i = 0; i < 8; i++) begin
                expanded[63-8*i -: 8] = {4'h0, nibbles[31-4*i -: 4]};
            end
        end
        default: ;                                  // BPP_8 and BPP_XX
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        buf_full_o <= 1'b0;
    end else begin
        if (take_i) begin
            buf_full_o <= 1'b0;
        end
        if (words_ready_i) begin
            buf_full_o <= 1'b1;
        end
        if (line_start_strobe_i) begin              // new line wins over a late load
            buf_full_o <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (words_ready_i) begin
        pixels_o <= expanded;
    end
end

endmodule

`default_nettype wire

// File: source/playfield_scanout.sv
// **********************************************************************
// playfield scanout
// runs the scan window, shifts pixels out with horizontal repeat
// and drives the colour index with border and colour base
// **********************************************************************
`default_nettype none
`timescale 1ns/1ns

module playfield_scanout #(
    parameter int REPEAT_W = 2                      // width of repeat count
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire playfield_pkg::hres_t       h_count_i,          // horizontal counter
    input  wire logic                       mem_fetch_i,        // line has display fetch
    input  wire logic                       mem_fetch_start_i,  // line fetch start strobe
    input  wire logic                       end_of_line_i,
    input  wire logic                       blank_i,            // show border only
    input  wire playfield_pkg::hres_t       vid_left_i,         // first visible count
    input  wire playfield_pkg::hres_t       vid_right_i,        // first border count on right
    input  wire logic [REPEAT_W-1:0]        h_repeat_i,         // extra cycles per pixel
    input  wire playfield_pkg::color_t      border_color_i,
    input  wire playfield_pkg::color_t      colorbase_i,        // xor onto every index
    input  wire playfield_pkg::pixels_t     pixels_i,           // next group from buffer
    output      logic                       take_o,             // buffer copied this cycle
    output      playfield_pkg::color_t      color_index_o
);

logic                   scanout;                    // inside scan window
logic                   scan_start;
logic                   scan_end;
logic                   shift_now;                  // repeat spent, next pixel
playfield_pkg::hres_t   start_hcount;               // count that starts the scan
playfield_pkg::hres_t   end_hcount;                 // count that ends the scan
logic [REPEAT_W-1:0]    h_cnt;                      // repeat countdown
logic [2:0]             col;                        // pixel within group
playfield_pkg::pixels_t pixels;                     // shift register, top byte shown

assign scan_start    = (h_count_i == start_hcount) && mem_fetch_i;
assign scan_end      = scanout && (h_count_i >= end_hcount);
assign shift_now     = scanout && (h_cnt == '0);
assign take_o        = scan_start || (shift_now && (col == 3'd7));
assign color_index_o = pixels[63:56] ^ colorbase_i;

always_ff @(posedge clk) begin
    if (reset_i) begin
        scanout      <= 1'b0;
        start_hcount <= '1;                         // out of range until first line
        end_hcount   <= '0;
        h_cnt        <= '0;
        col          <= '0;
        pixels       <= '0;
    end else begin
        if (scanout) begin
            if (h_cnt != '0) begin
                h_cnt <= h_cnt - 1'b1;
            end else begin
                h_cnt <= h_repeat_i;
                col   <= col + 1'b1;
                if (col == 3'd7) begin
                    pixels <= pixels_i;             // eighth pixel done, next group
                end else begin
                    pixels <= {pixels[55:0], border_color_i};
                end
            end
        end
        if (mem_fetch_start_i) begin
            start_hcount <= vid_left_i - playfield_pkg::hres_t'(playfield_pkg::SCAN_LEAD);
            end_hcount   <= vid_right_i - 11'd1;    // registered, so border shows at vid_right
        end
        if (scan_start) begin
            scanout <= 1'b1;
            h_cnt   <= h_repeat_i;
            col     <= '0;
            pixels  <= pixels_i;                    // first group of the line
        end
        if (scan_end || end_of_line_i || blank_i) begin
            scanout        <= 1'b0;
            pixels[63:56]  <= border_color_i;
        end
    end
end

endmodule

`default_nettype wire

// File: source/playfield_line_ctrl.sv
// **********************************************************************
// playfield line control
// keeps the line start address with vertical repeat and restarts
// at the frame start address on end of frame or blank
// **********************************************************************
`default_nettype none
`timescale 1ns/1ns

module playfield_line_ctrl #(
    parameter int REPEAT_W = 2                      // width of repeat count
) (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       end_of_line_i,
    input  wire logic                       end_of_frame_i,
    input  wire logic                       blank_i,
    input  wire playfield_pkg::addr_t       start_addr_i,       // frame start address
    input  wire playfield_pkg::word_t       line_len_i,         // words per line stride
    input  wire logic [REPEAT_W-1:0]        v_repeat_i,         // extra showings per line
    output      playfield_pkg::addr_t       line_start_o        // start of current line
);

logic [REPEAT_W-1:0] v_cnt;                         // showings left for this line

always_ff @(posedge clk) begin
    if (reset_i) begin
        line_start_o <= '0;
        v_cnt        <= '0;
    end else begin
        if (end_of_line_i) begin
            if (v_cnt != '0) begin
                v_cnt <= v_cnt - 1'b1;              // same line again
            end else begin
                v_cnt        <= v_repeat_i;
                line_start_o <= line_start_o + line_len_i;
            end
        end
        if (end_of_frame_i || blank_i) begin        // back to top of frame
            line_start_o <= start_addr_i;
            v_cnt        <= v_repeat_i;
        end
    end
end

endmodule

`default_nettype wire

// File: source/video_playfield.sv
// **********************************************************************
// bitmap playfield line generator
// fetch, pixel buffer, scanout and line control for one playfield
// **********************************************************************
`default_nettype none
`timescale 1ns/1ns

module video_playfield #(
    parameter int REPEAT_W = 2                      // width of h and v repeat
) (
    input  wire logic                       stall_i,            // vram busy this cycle
    input  wire playfield_pkg::hres_t       h_count_i,
    input  wire logic                       mem_fetch_i,
    input  wire logic                       mem_fetch_start_i,
    input  wire logic                       end_of_line_i,
    input  wire logic                       end_of_frame_i,
    input  wire playfield_pkg::color_t      border_color_i,
    input  wire playfield_pkg::hres_t       vid_left_i,
    input  wire playfield_pkg::hres_t       vid_right_i,
    output      logic                       vram_sel_o,
    output      playfield_pkg::addr_t       vram_addr_o,
    input  wire playfield_pkg::word_t       vram_data_i,
    input  wire logic                       pf_blank_i,
    input  wire playfield_pkg::addr_t       pf_start_addr_i,
    input  wire playfield_pkg::word_t       pf_line_len_i,
    input  wire playfield_pkg::color_t      pf_colorbase_i,
    input  wire playfield_pkg::bpp_t        pf_bpp_i,
    input  wire logic [REPEAT_W-1:0]        pf_h_repeat_i,
    input  wire logic [REPEAT_W-1:0]        pf_v_repeat_i,
    output      playfield_pkg::color_t      pf_color_index_o,
    input  wire logic                       reset_i,
    input  wire logic                       clk
);

logic                       words_ready;            // fetch group complete
playfield_pkg::pf_words_t   words;
logic                       buf_full;               // pixel buffer occupied
logic                       take;                   // scanout took the buffer
playfield_pkg::pixels_t     pixels_buf;
playfield_pkg::addr_t       line_start;

playfield_fetch fetch_i (
    .clk               (clk),
    .reset_i           (reset_i),
    .stall_i           (stall_i),
    .mem_fetch_start_i (mem_fetch_start_i),
    .end_of_line_i     (end_of_line_i),
    .bpp_i             (pf_bpp_i),
    .line_start_i      (line_start),
    .buf_full_i        (buf_full),
    .vram_sel_o        (vram_sel_o),
    .vram_addr_o       (vram_addr_o),
    .vram_data_i       (vram_data_i),
    .words_ready_o     (words_ready),
    .words_o           (words)
);

playfield_expand expand_i (
    .clk                 (clk),
    .reset_i             (reset_i),
    .bpp_i               (pf_bpp_i),
    .words_ready_i       (words_ready),
    .words_i             (words),
    .take_i              (take),
    .line_start_strobe_i (mem_fetch_start_i),
    .buf_full_o          (buf_full),
    .pixels_o            (pixels_buf)
);

playfield_scanout #(.REPEAT_W(REPEAT_W)) scanout_i (
    .clk               (clk),
    .reset_i           (reset_i),
    .h_count_i         (h_count_i),
    .mem_fetch_i       (mem_fetch_i),
    .mem_fetch_start_i (mem_fetch_start_i),
    .end_of_line_i     (end_of_line_i),
    .blank_i           (pf_blank_i),
    .vid_left_i        (vid_left_i),
    .vid_right_i       (vid_right_i),
    .h_repeat_i        (pf_h_repeat_i),
    .border_color_i    (border_color_i),
    .colorbase_i       (pf_colorbase_i),
    .pixels_i          (pixels_buf),
    .take_o            (take),
    .color_index_o     (pf_color_index_o)
);

playfield_line_ctrl #(.REPEAT_W(REPEAT_W)) line_ctrl_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .end_of_line_i  (end_of_line_i),
    .end_of_frame_i (end_of_frame_i),
    .blank_i        (pf_blank_i),
    .start_addr_i   (pf_start_addr_i),
    .line_len_i     (pf_line_len_i),
    .v_repeat_i     (pf_v_repeat_i),
    .line_start_o   (line_start)
);

endmodule

`default_nettype wire

// File: verif/playfield_assertions.sv
// **********************************************************************
// playfield assertions
// port level checks on reset, stall hold and left border colour
// **********************************************************************
`default_nettype none
`timescale 1ns/1ns

module playfield_assertions (
    input wire logic                    clk,
    input wire logic                    reset_i,
    input wire logic                    stall_i,
    input wire logic                    end_of_line_i,
    input wire playfield_pkg::hres_t    h_count_i,
    input wire playfield_pkg::hres_t    vid_left_i,
    input wire playfield_pkg::color_t   border_color_i,
    input wire playfield_pkg::color_t   pf_colorbase_i,
    input wire logic                    vram_sel_o,
    input wire playfield_pkg::addr_t    vram_addr_o,
    input wire playfield_pkg::color_t   pf_color_index_o
);

logic armed;                                        // a line has ended since reset

always_ff @(posedge clk) begin
    if (reset_i) begin
        armed <= 1'b0;
    end else if (end_of_line_i) begin
        armed <= 1'b1;
    end
end

sel_after_reset: assert property (@(posedge clk) reset_i |=> !vram_sel_o)
    else $error("vram select high after reset");

hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
    stall_i |=> $stable(vram_addr_o) && $stable(vram_sel_o))
    else $error("vram request changed across a stalled cycle");

left_border: assert property (@(posedge clk) disable iff (reset_i)
    armed && (h_count_i < vid_left_i) |-> pf_color_index_o == (border_color_i ^ pf_colorbase_i))
    else $error("colour left of the window is not the border");

endmodule

bind video_playfield playfield_assertions assertions_i (
    .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .end_of_line_i(end_of_line_i),
    .h_count_i(h_count_i), .vid_left_i(vid_left_i), .border_color_i(border_color_i),
    .pf_colorbase_i(pf_colorbase_i), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
    .pf_color_index_o(pf_color_index_o)
);

`default_nettype wire

// File: verif/playfield_tb.sv
// **********************************************************************
// playfield testbench
// drives timing, stalls and settings per test from the test file,
// models the vram and checks every pixel and each line's first read
// **********************************************************************
`default_nettype none
`timescale 1ns/1ns

module playfield_tb;

localparam int LINE_COUNTS  = 200;                  // counts per line
localparam int VID_LEFT     = 40;
localparam int VID_RIGHT    = 168;
localparam int READ_TIMEOUT = 24;                   // cycles to wait for first read
localparam int MAX_TESTS    = 64;

logic                       clk;
logic                       reset_i;
logic                       stall_i;
playfield_pkg::hres_t       h_count_i;
logic                       mem_fetch_i;
logic                       mem_fetch_start_i;
logic                       end_of_line_i;
logic                       end_of_frame_i;
playfield_pkg::color_t      border_color_i;
playfield_pkg::hres_t       vid_left_i;
playfield_pkg::hres_t       vid_right_i;
logic                       vram_sel_o;
playfield_pkg::addr_t       vram_addr_o;
playfield_pkg::word_t       vram_data_i;
logic                       pf_blank_i;
playfield_pkg::addr_t       pf_start_addr_i;
playfield_pkg::word_t       pf_line_len_i;
playfield_pkg::color_t      pf_colorbase_i;
playfield_pkg::bpp_t        pf_bpp_i;
logic [1:0]                 pf_h_repeat_i;
logic [1:0]                 pf_v_repeat_i;
playfield_pkg::color_t      pf_color_index_o;

playfield_pkg::word_t       vram [65536];           // vram contents
string                      t_name [MAX_TESTS];
int                         t_bpp [MAX_TESTS], t_hrep [MAX_TESTS], t_vrep [MAX_TESTS];
int                         t_start [MAX_TESTS], t_stride [MAX_TESTS], t_cb [MAX_TESTS];
int                         t_border [MAX_TESTS], t_stall [MAX_TESTS], t_blank [MAX_TESTS];
int                         t_lines [MAX_TESTS];
int                         num_tests;
int                         drv_test;               // test whose settings are driven
int                         chk_test, chk_line;     // line under check
bit                         checking;
int                         cyc;                    // cycle count for stall pattern
int                         color_errors, addr_errors, timeout_errors;

video_playfield #(.REPEAT_W(2)) dut_i (
    .stall_i(stall_i), .h_count_i(h_count_i), .mem_fetch_i(mem_fetch_i),
    .mem_fetch_start_i(mem_fetch_start_i), .end_of_line_i(end_of_line_i),
    .end_of_frame_i(end_of_frame_i), .border_color_i(border_color_i),
    .vid_left_i(vid_left_i), .vid_right_i(vid_right_i), .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i), .pf_blank_i(pf_blank_i),
    .pf_start_addr_i(pf_start_addr_i), .pf_line_len_i(pf_line_len_i),
    .pf_colorbase_i(pf_colorbase_i), .pf_bpp_i(pf_bpp_i), .pf_h_repeat_i(pf_h_repeat_i),
    .pf_v_repeat_i(pf_v_repeat_i), .pf_color_index_o(pf_color_index_o),
    .reset_i(reset_i), .clk(clk)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                          // 8 ns period
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// vram model answers an unstalled select one cycle later
always @(posedge clk) begin
    if (vram_sel_o && !stall_i) begin
        vram_data_i <= vram[vram_addr_o];
    end
end

task automatic fill_vram();
    logic [31:0] s;
    s = 32'ha0a7;
    for (int i = 0; i < 65536; i++) begin
        s = lcg_next(s);
        vram[i] = s[31:16];                         // upper half of the generator state
    end
endtask

task automatic load_tests();
    int    fd;
    int    n;
    string line_s;
    fd = $fopen("verif/playfield_tests.txt", "r");
    num_tests = 0;
    if (fd == 0) begin
        $display("could not open the test file verif/playfield_tests.txt");
        timeout_errors++;
        return;
    end
    while (!$feof(fd) && num_tests < MAX_TESTS) begin
        line_s = "";
        n = $fgets(line_s, fd);
        if (line_s.len() < 2 || line_s.getc(0) == "#") continue;   // header or blank line
        n = $sscanf(line_s, "%s %d %d %d %h %h %h %h %d %d %d", t_name[num_tests],
                    t_bpp[num_tests], t_hrep[num_tests], t_vrep[num_tests],
                    t_start[num_tests], t_stride[num_tests], t_cb[num_tests],
                    t_border[num_tests], t_stall[num_tests], t_blank[num_tests],
                    t_lines[num_tests]);
        if (n == 11) num_tests++;
    end
    $fclose(fd);
endtask

task automatic apply_test(input int t);
    drv_test        = t;
    pf_bpp_i        <= playfield_pkg::bpp_t'(t_bpp[t]);
    pf_h_repeat_i   <= 2'(t_hrep[t]);
    pf_v_repeat_i   <= 2'(t_vrep[t]);
    pf_start_addr_i <= playfield_pkg::addr_t'(t_start[t]);
    pf_line_len_i   <= playfield_pkg::word_t'(t_stride[t]);
    pf_colorbase_i  <= playfield_pkg::color_t'(t_cb[t]);
    border_color_i  <= playfield_pkg::color_t'(t_border[t]);
    pf_blank_i      <= (t_blank[t] != 0);
endtask

// start of line l counted from the frame restart that opens test t
function automatic playfield_pkg::addr_t line_start(input int t, input int l);
    if (t_blank[t] != 0) return playfield_pkg::addr_t'(t_start[t]);
    return playfield_pkg::addr_t'(t_start[t] + (l / (t_vrep[t] + 1)) * t_stride[t]);
endfunction

function automatic playfield_pkg::color_t expected_pixel(input int t, input int l, input int h);
    int                    idx, pos, wpg;
    playfield_pkg::addr_t  base;
    playfield_pkg::word_t  w;
    logic [3:0]            nib;
    playfield_pkg::color_t px;
    if (t_blank[t] != 0 || h < VID_LEFT || h >= VID_RIGHT) begin
        return playfield_pkg::color_t'(t_border[t] ^ t_cb[t]);
    end
    idx  = (h - VID_LEFT) / (t_hrep[t] + 1);
    pos  = idx % 8;
    wpg  = (t_bpp[t] == 0) ? 1 : (t_bpp[t] == 1) ? 2 : 4;
    base = line_start(t, l) + playfield_pkg::addr_t'((idx / 8) * wpg);
    case (t_bpp[t])
        0: begin                                    // set bit picks foreground nibble
            w   = vram[base];
            nib = w[7-pos] ? w[11:8] : w[15:12];
            px  = {4'h0, nib};
        end
        1: begin
            w   = vram[base + playfield_pkg::addr_t'(pos / 4)];
            nib = w[15-4*(pos%4) -: 4];
            px  = {4'h0, nib};
        end
        default: begin
            w  = vram[base + playfield_pkg::addr_t'(pos / 2)];
            px = (pos % 2 == 0) ? w[15:8] : w[7:0];
        end
    endcase
    return px ^ playfield_pkg::color_t'(t_cb[t]);
endfunction

task automatic check_color(input string name, input playfield_pkg::color_t exp,
                           input playfield_pkg::color_t act);
    if (exp !== act) begin
        color_errors++;
        $display("[ERROR] %s: colour at h %0d expected %h, actual %h", name, h_count_i, exp, act);
    end
endtask

task automatic check_addr(input string name, input playfield_pkg::addr_t exp,
                          input playfield_pkg::addr_t act);
    if (exp !== act) begin
        addr_errors++;
        $display("[ERROR] %s: first read address expected %h, actual %h", name, exp, act);
    end
endtask

task automatic drive_line(input int t, input int l, input bit last, input bit lead_in);
    for (int c = 0; c < LINE_COUNTS; c++) begin
        @(posedge clk);
        if (c == 0) begin
            checking = !lead_in;
            chk_test = t;
            chk_line = l;
        end
        h_count_i         <= playfield_pkg::hres_t'(c);
        mem_fetch_start_i <= (c == 2);
        end_of_line_i     <= (c == LINE_COUNTS - 1);
        end_of_frame_i    <= (c == LINE_COUNTS - 1) && last;
        stall_i <= (t_stall[drv_test] != 0) && (cyc % t_stall[drv_test] == t_stall[drv_test] - 1);
        cyc++;
        if (c == LINE_COUNTS - 1 && last && t + 1 < num_tests) begin
            apply_test(t + 1);                      // latched with the frame end
        end
    end
endtask

// first rising select after the line start strobe skips stale reads
task automatic wait_first_read();
    int                   n;
    logic                 prev;
    bit                   found;
    playfield_pkg::addr_t exp;
    exp   = line_start(chk_test, chk_line);
    prev  = 1'b1;
    found = 1'b0;
    n     = 0;
    while (!found && n < READ_TIMEOUT) begin
        @(negedge clk);
        if (vram_sel_o && !prev) begin
            found = 1'b1;
            check_addr(t_name[chk_test], exp, vram_addr_o);
        end
        prev = vram_sel_o;
        n++;
    end
    if (!found) begin
        timeout_errors++;
        $display("timeout: no VRAM read after the line fetch start in test %s", t_name[chk_test]);
    end
endtask

always begin
    @(negedge clk);
    if (checking && mem_fetch_start_i) wait_first_read();
end

always @(negedge clk) begin
    if (checking && h_count_i < LINE_COUNTS - 1) begin
        check_color(t_name[chk_test], expected_pixel(chk_test, chk_line, h_count_i),
                    pf_color_index_o);
    end
end

initial begin
    checking = 1'b0;
    cyc = 0;
    color_errors = 0;
    addr_errors = 0;
    timeout_errors = 0;
    reset_i <= 1'b1;
    stall_i <= 1'b0;
    h_count_i <= '0;
    mem_fetch_i <= 1'b1;                            // every line fetches
    mem_fetch_start_i <= 1'b0;
    end_of_line_i <= 1'b0;
    end_of_frame_i <= 1'b0;
    vid_left_i <= playfield_pkg::hres_t'(VID_LEFT);
    vid_right_i <= playfield_pkg::hres_t'(VID_RIGHT);
    vram_data_i <= '0;
    fill_vram();
    load_tests();
    apply_test(0);
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;
    if (num_tests > 0) drive_line(-1, 0, 1'b1, 1'b1);     // lead-in line ends in frame restart
    for (int t = 0; t < num_tests; t++) begin
        for (int l = 0; l < t_lines[t]; l++) begin
            drive_line(t, l, l == t_lines[t] - 1, 1'b0);
        end
    end
    @(posedge clk);
    checking = 1'b0;
    $display("tests %0d, colour errors %0d, address errors %0d, timeouts %0d",
             num_tests, color_errors, addr_errors, timeout_errors);
    if (num_tests > 0 && color_errors + addr_errors + timeout_errors == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: verif/playfield_tests.txt
# name depth h_repeat v_repeat start(hex) stride(hex) colorbase(hex) border(hex)
# stall_every(0 none) blank line_count
bpp1_plain     0 0 0 0100 0040 00 05 0 0 2
bpp4_plain     1 0 0 0300 0040 a0 11 0 0 2
bpp8_plain     2 0 0 0800 0080 00 22 0 0 2
bppxx_plain    3 0 0 1000 0080 3c 0f 0 0 1
hrep1_bpp8     2 1 0 2000 0040 00 33 0 0 2
hrep2_bpp4     1 2 0 2400 0020 5a 44 0 0 2
hrep3_bpp1     0 3 0 2800 0010 0f 55 0 0 2
vrep1_bpp4     1 0 1 3000 0040 00 66 0 0 5
vrep3_bpp8     2 0 3 3800 0080 81 77 0 0 9
vrep2_bpp1     0 1 2 fff0 0020 00 01 0 0 7
stall4_bpp8    2 1 0 4000 0040 00 88 4 0 3
stall4_bpp4    1 1 0 4400 0040 c3 99 4 0 3
stall4_bpp1    0 1 0 4800 0040 00 aa 4 0 3
blank_on       1 0 1 5000 0040 12 bb 0 1 3
after_blank    1 0 1 5000 0040 12 bb 0 0 4
frame_again    2 0 0 0800 0080 00 22 0 0 2

// File: compile.f
source/playfield_pkg.sv
source/playfield_fetch.sv
source/playfield_expand.sv
source/playfield_scanout.sv
source/playfield_line_ctrl.sv
source/video_playfield.sv
verif/playfield_assertions.sv
verif/playfield_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the playfield testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module playfield_tb \
    -f compile.f -o playfield_sim &&
./obj_dir/playfield_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
